/* hw/umi_pkg.sv */
// umi request definitions: atomic opcodes, size, length and byte count types

package umi_pkg;

   // ####################
   // atomic operations
   // ####################

   // codes as carried in the atype field
   // anything not listed falls back to swap
   typedef enum logic [7:0] {
      atomic_add  = 8'd0,
      atomic_and  = 8'd1,
      atomic_or   = 8'd2,
      atomic_xor  = 8'd3,
      atomic_max  = 8'd4,  // signed
      atomic_min  = 8'd5,  // signed
      atomic_maxu = 8'd6,
      atomic_minu = 8'd7,
      atomic_swap = 8'd8
   } atype_t;

   // ####################
   // transfer fields
   // ####################

   typedef logic [2:0] size_t;   // log2 bytes per transfer
   typedef logic [7:0] len_t;    // transfers minus one

   // total bytes of one request
   // 12 bits is enough for 256 transfers of up to 8 bytes
   typedef logic [11:0] bytes_t;

endpackage

/* hw/mem_pkg.sv */
// memory side definitions: byte width and byte offset width function

package mem_pkg;

   localparam int byte_w = 8;  // bits per byte lane

   // bits of byte offset inside a dw wide word
   function automatic int off_w(input int dw);
      int nbytes;
      nbytes = dw / byte_w;
      if (nbytes <= 1) begin
         return 1;  // keep a legal vector width
      end
      return $clog2(nbytes);
   endfunction

endpackage

/* hw/mem_if.sv */
// sram port bundle with controller and memory modports

`timescale 1ns/100ps

interface mem_if #(
   parameter int DW  = 64,
   parameter int MAW = 11
);

   logic           ce;      // access this cycle
   logic           we;      // write, else read
   logic [MAW-1:0] addr;    // byte address
   logic [DW-1:0]  wrmask;  // one bit per data bit
   logic [DW-1:0]  wrdata;
   logic [DW-1:0]  rddata;  // word from previous access

   // request side
   modport ctrl (output ce, we, addr, wrmask, wrdata, input rddata);

   // storage side
   modport mem (input ce, we, addr, wrmask, wrdata, output rddata);

endinterface

/* hw/umi_atomic_alu.sv */
// atomic operation unit on top aligned fields

`timescale 1ns/100ps

module umi_atomic_alu #(
   parameter int DW = 64
) (
   input  umi_pkg::atype_t atype,    // operation code
   input  logic [DW-1:0]   operand,  // request data, top aligned
   input  logic [DW-1:0]   memval,   // old field, top aligned
   output logic [DW-1:0]   result
);
   import umi_pkg::*;
   import mem_pkg::*;

   localparam int NB = DW / byte_w;  // byte lanes per word

   logic [DW-1:0] and_v;
   logic [DW-1:0] or_v;
   logic [DW-1:0] xor_v;
   logic          gt_s;  // operand > memval, signed
   logic          gt_u;  // operand > memval, unsigned

   // logic ops lane by lane
   always_comb begin
      for (int i = 0; i < NB; i++) begin
         and_v[i*byte_w +: byte_w] = operand[i*byte_w +: byte_w] & memval[i*byte_w +: byte_w];
         or_v[i*byte_w +: byte_w]  = operand[i*byte_w +: byte_w] | memval[i*byte_w +: byte_w];
         xor_v[i*byte_w +: byte_w] = operand[i*byte_w +: byte_w] ^ memval[i*byte_w +: byte_w];
      end
   end

   // field msb sits at DW-1 so the sign is the field's own
   assign gt_s = $signed(operand) > $signed(memval);
   assign gt_u = operand > memval;

   always_comb begin
      case (atype)
         atomic_add:  result = operand + memval;  // carry out of field drops off the top
         atomic_and:  result = and_v;
         atomic_or:   result = or_v;
         atomic_xor:  result = xor_v;
         atomic_max:  result = gt_s ? operand : memval;
         atomic_min:  result = gt_s ? memval : operand;
         atomic_maxu: result = gt_u ? operand : memval;
         atomic_minu: result = gt_u ? memval : operand;
         default:     result = operand;  // swap and unknown codes
      endcase
   end

endmodule

/* hw/umi_memif.sv */
// umi request to sram translation: byte mask, alignment, two cycle atomics

`timescale 1ns/100ps

module umi_memif #(
   parameter int DW  = 64,  // word width
   parameter int AW  = 64,  // request address width
   parameter int MAW = 11   // memory byte address width
) (
   input  logic            clk,
   input  logic            nreset,
   input  logic            read,     // read request
   input  logic            write,    // write request
   input  logic            atomic,   // read-modify-write request
   input  umi_pkg::size_t  size,     // log2 bytes per transfer
   input  umi_pkg::len_t   len,      // transfers minus one
   input  umi_pkg::atype_t atype,    // atomic opcode
   input  logic [AW-1:0]   addr,
   input  logic [DW-1:0]   wrdata,
   output logic [DW-1:0]   rddata,   // valid the cycle after a read
   output logic            ready,    // low during atomic write back
   mem_if.ctrl             mem
);
   import umi_pkg::*;
   import mem_pkg::*;

   localparam int OW = off_w(DW);
   localparam int NB = DW / byte_w;

   // request decode
   logic [OW-1:0]  off;        // byte offset in word
   bytes_t         off_ext;
   bytes_t         lenp1;
   bytes_t         nbytes;     // bytes in this request
   bytes_t         fld_shift;  // moves field from bit 0 to the top
   bytes_t         top_shift;  // moves field from its lane to the top
   logic [DW-1:0]  mask;

   // state held across the access
   logic           atomic_r;
   logic [MAW-1:0] addr_r;
   atype_t         atype_r;
   logic [OW-1:0]  off_r;
   logic [DW-1:0]  mask_r;
   logic [DW-1:0]  operand_r;  // top aligned atomic operand
   bytes_t         shift_r;

   // atomic datapath
   logic [DW-1:0]  old_field;
   logic [DW-1:0]  result;

   // ####################
   // byte mask
   // ####################

   assign off     = addr[OW-1:0];
   assign off_ext = bytes_t'(off);
   assign lenp1   = bytes_t'(len) + bytes_t'(1);
   assign nbytes  = lenp1 << size;

   assign fld_shift = bytes_t'(DW) - bytes_t'(nbytes * byte_w);
   assign top_shift = bytes_t'(DW) - bytes_t'((off_ext + nbytes) * byte_w);

   // lanes from off up to off+nbytes, no word crossing
   always_comb begin
      for (int i = 0; i < NB; i++) begin
         if ((i >= off_ext) && (i < off_ext + nbytes))
            mask[i*byte_w +: byte_w] = {byte_w{1'b1}};
         else
            mask[i*byte_w +: byte_w] = {byte_w{1'b0}};
      end
   end

   // ####################
   // request registers
   // ####################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         atomic_r <= 1'b0;
      else
         atomic_r <= atomic & ready;  // second atomic cycle
   end

   // held while ready is low, so the write back sees cycle n values
   always_ff @(posedge clk) begin
      if (ready) begin
         addr_r    <= addr[MAW-1:0];
         atype_r   <= atype;
         off_r     <= off;
         mask_r    <= mask;
         operand_r <= wrdata << fld_shift;
         shift_r   <= top_shift;
      end
   end

   assign ready = ~atomic_r;

   // read data, addressed bytes only, moved down to bit 0
   assign rddata = (mem.rddata & mask_r) >> (off_r * byte_w);

   // ####################
   // atomic write back
   // ####################

   assign old_field = (mem.rddata & mask_r) << shift_r;  // top aligned, low bits zero

   umi_atomic_alu #(.DW(DW)) u_alu (
      .atype   (atype_r),
      .operand (operand_r),
      .memval  (old_field),
      .result  (result)
   );

   // sram port
   assign mem.ce     = (ready & (read | write | atomic)) | atomic_r;
   assign mem.we     = (ready & write) | atomic_r;
   assign mem.addr   = atomic_r ? addr_r : addr[MAW-1:0];
   assign mem.wrmask = atomic_r ? mask_r : mask;
   assign mem.wrdata = atomic_r ? (result >> shift_r)      // back into its lanes
                                : (wrdata << (off * byte_w));

endmodule

/* hw/umi_sram.sv */
// single port synchronous sram with bit write mask and one cycle read

`timescale 1ns/100ps

module umi_sram #(
   parameter int DW  = 64,  // word width
   parameter int MAW = 11   // byte address width
) (
   input logic clk,
   mem_if.mem  mem
);
   import mem_pkg::*;

   localparam int OW    = off_w(DW);
   localparam int NB    = DW / byte_w;
   localparam int DEPTH = 2 ** (MAW - OW);  // words

   logic [DW-1:0]     ram [DEPTH];
   logic [MAW-OW-1:0] idx;  // word index

   assign idx = mem.addr[MAW-1:OW];  // drop byte offset

   // ####################
   // access
   // ####################

   always_ff @(posedge clk) begin
      if (mem.ce) begin
         if (mem.we) begin
            // merge per lane, masked bits take new data
            for (int i = 0; i < NB; i++) begin
               ram[idx][i*byte_w +: byte_w] <=
                  (ram[idx][i*byte_w +: byte_w] & ~mem.wrmask[i*byte_w +: byte_w]) |
                  (mem.wrdata[i*byte_w +: byte_w] & mem.wrmask[i*byte_w +: byte_w]);
            end
         end
         mem.rddata <= ram[idx];  // old word on a write cycle
      end
   end

endmodule

/* hw/umi_mem_top.sv */
// memory endpoint top: request interface joined to the sram

`timescale 1ns/100ps

module umi_mem_top #(
   parameter int DW  = 64,  // word width
   parameter int AW  = 64,  // request address width
   parameter int MAW = 11   // 256 words at 64 bits
) (
   input  logic            clk,
   input  logic            nreset,
   // umi request port
   input  logic            read,
   input  logic            write,
   input  logic            atomic,
   input  umi_pkg::size_t  size,
   input  umi_pkg::len_t   len,
   input  umi_pkg::atype_t atype,
   input  logic [AW-1:0]   addr,
   input  logic [DW-1:0]   wrdata,
   output logic [DW-1:0]   rddata,
   output logic            ready
);

   // sram port between controller and memory
   mem_if #(.DW(DW), .MAW(MAW)) mem_bus ();

   umi_memif #(.DW(DW), .AW(AW), .MAW(MAW)) u_memif (
      .clk    (clk),
      .nreset (nreset),
      .read   (read),
      .write  (write),
      .atomic (atomic),
      .size   (size),
      .len    (len),
      .atype  (atype),
      .addr   (addr),
      .wrdata (wrdata),
      .rddata (rddata),
      .ready  (ready),
      .mem    (mem_bus.ctrl)
   );

   // storage, no reset
   umi_sram #(.DW(DW), .MAW(MAW)) u_sram (
      .clk (clk),
      .mem (mem_bus.mem)
   );

endmodule

/* sim/umi_mem_checker.sv */
// concurrent assertions on the umi request handshake, bound into umi_memif

`timescale 1ns/100ps

module umi_mem_checker #(
   parameter int DW  = 64,
   parameter int MAW = 11
) (
   input logic           clk,
   input logic           nreset,
   input logic           read,
   input logic           write,
   input logic           atomic,
   input logic           ready,
   input logic           ce,        // sram access
   input logic           we,        // sram write enable
   input logic [MAW-1:0] mem_addr,  // sram byte address
   input logic [DW-1:0]  wrmask     // sram bit write mask
);

   int fail_count = 0;  // failed assertions so far

   // atomic accepted -> one busy cycle, then ready again
   a_ready_one_cycle: assert property (@(posedge clk) disable iff (!nreset)
      (atomic && ready) |=> !ready ##1 ready)
      else begin
         fail_count++;
         $error("ready not low for exactly one cycle after atomic");
      end

   // requester must hold off while busy
   a_no_req_busy: assert property (@(posedge clk) disable iff (!nreset)
      !ready |-> !(read || write || atomic))
      else begin
         fail_count++;
         $error("request issued while ready low");
      end

   // write back cycle, same word and lanes as the atomic read
   a_we_after_atomic: assert property (@(posedge clk) disable iff (!nreset)
      (atomic && ready) |=> (ce && we && (mem_addr == $past(mem_addr)) &&
                             (wrmask == $past(wrmask))))
      else begin
         fail_count++;
         $error("atomic write back missing or not at the atomic's address and lanes");
      end

endmodule

bind umi_memif umi_mem_checker #(.DW(DW), .MAW(MAW)) chk (
   .clk      (clk),
   .nreset   (nreset),
   .read     (read),
   .write    (write),
   .atomic   (atomic),
   .ready    (ready),
   .ce       (mem.ce),
   .we       (mem.we),
   .mem_addr (mem.addr),
   .wrmask   (mem.wrmask)
);

/* sim/tb_umi_mem.sv */
// directed testbench for umi_mem_top: clock, reset, byte reference model, tests, result

`timescale 1ns/100ps

module tb_umi_mem;
   import umi_pkg::*;

   localparam int DW  = 64;
   localparam int AW  = 64;
   localparam int MAW = 11;
   localparam int est_cycles = 1000;            // all tests, rounded up
   localparam int max_cycles = 2 * est_cycles;

   logic clk, nreset, read, write, atomic, ready;
   size_t size;
   len_t len;
   atype_t atype;
   logic [AW-1:0] addr;
   logic [DW-1:0] wrdata, rddata;

   logic [7:0] ref_mem [0:2**MAW-1];  // byte model of the sram
   integer seed = 56826;
   int errors = 0, checks = 0, err_mark = 0, cycles = 0;
   int assert_fails = 0;  // from the bound checker

   umi_mem_top #(.DW(DW), .AW(AW), .MAW(MAW)) UUT (
      .clk(clk), .nreset(nreset), .read(read), .write(write), .atomic(atomic),
      .size(size), .len(len), .atype(atype), .addr(addr), .wrdata(wrdata),
      .rddata(rddata), .ready(ready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   // timeout watchdog
   initial begin
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $finish;
   end

   // ####################
   // helpers
   // ####################

   task automatic tick();
      @(posedge clk);
      #1;  // drive point
   endtask

   task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("** Error: %s = 0x%h, expected 0x%h", name, act, exp);
      end
   endtask

   task automatic end_test(input string name);
      $display("%s: %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   function automatic logic [63:0] rand64();
      return {$random(seed), $random(seed)};
   endfunction

   function automatic int byte_count(input size_t sz, input len_t ln);
      return (int'(ln) + 1) << sz;
   endfunction

   function automatic logic [63:0] field_mask(input int nb);
      if (nb >= 8) return '1;
      return (64'd1 << (8 * nb)) - 64'd1;
   endfunction

   function automatic logic [63:0] ref_field(input logic [63:0] a, input int nb);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < nb; i++) v[8*i +: 8] = ref_mem[int'(a[MAW-1:0]) + i];
      return v;  // low bytes first
   endfunction

   task automatic store_ref(input logic [63:0] a, input int nb, input logic [63:0] v);
      for (int i = 0; i < nb; i++) ref_mem[int'(a[MAW-1:0]) + i] = v[8*i +: 8];
   endtask

   // expected atomic result on an nb byte field
   function automatic logic [63:0] atomic_expect(input atype_t op, input logic [63:0] old_v,
                                                 input logic [63:0] opnd, input int nb);
      logic [63:0] fm, a, m, sa, sm;
      fm = field_mask(nb);
      a  = opnd & fm;
      m  = old_v & fm;
      sa = a[8*nb-1] ? (a | ~fm) : a;  // sign extend
      sm = m[8*nb-1] ? (m | ~fm) : m;
      case (op)
         atomic_add:  return (a + m) & fm;
         atomic_and:  return a & m;
         atomic_or:   return a | m;
         atomic_xor:  return a ^ m;
         atomic_max:  return ($signed(sa) > $signed(sm)) ? a : m;
         atomic_min:  return ($signed(sa) < $signed(sm)) ? a : m;
         atomic_maxu: return (a > m) ? a : m;
         atomic_minu: return (a < m) ? a : m;
         default:     return a;  // swap
      endcase
   endfunction

   task automatic set_req(input logic r, input logic w, input logic at, input logic [63:0] a,
                          input size_t sz, input len_t ln, input logic [63:0] d);
      read   = r;
      write  = w;
      atomic = at;
      addr   = a;
      size   = sz;
      len    = ln;
      wrdata = d;
   endtask

   task automatic idle();
      set_req(1'b0, 1'b0, 1'b0, '0, '0, '0, '0);
      tick();
   endtask

   task automatic issue_write(input logic [63:0] a, input size_t sz, input len_t ln,
                              input logic [63:0] d);
      set_req(1'b0, 1'b1, 1'b0, a, sz, ln, d);
      store_ref(a, byte_count(sz, ln), d);
      tick();
   endtask

   // read, then check in the following cycle
   task automatic read_check(input logic [63:0] a, input size_t sz, input len_t ln);
      set_req(1'b1, 1'b0, 1'b0, a, sz, ln, '0);
      tick();
      check_value("rddata", rddata, ref_field(a, byte_count(sz, ln)));
   endtask

   task automatic run_atomic(input logic [63:0] a, input size_t sz, input len_t ln,
                             input atype_t op, input logic [63:0] opnd);
      int nb;
      logic [63:0] old_v;
      nb    = byte_count(sz, ln);
      old_v = ref_field(a, nb);
      set_req(1'b0, 1'b0, 1'b1, a, sz, ln, opnd);
      atype = op;
      tick();
      set_req(1'b0, 1'b0, 1'b0, '0, '0, '0, '0);  // hold off while busy
      check_value("ready", ready, 1'b0);
      check_value("rddata", rddata, old_v);  // old field
      store_ref(a, nb, atomic_expect(op, old_v, opnd, nb));
      while (!ready) tick();  // watchdog bounds this
   endtask

   // ####################
   // tests
   // ####################

   task automatic test_reset();
      check_value("ready", ready, 1'b1);
      check_value("mem.ce", UUT.mem_bus.ce, 1'b0);
      check_value("mem.we", UUT.mem_bus.we, 1'b0);
      end_test("reset state");
   endtask

   task automatic test_full_words();
      for (int w = 0; w < 32; w++) issue_write(64'(w * 8), 3'd3, 8'd0, rand64());
      for (int w = 0; w < 32; w++) read_check(64'(w * 8), 3'd3, 8'd0);
      idle();
      end_test("full word write/read");
   endtask

   task automatic test_partial();
      int     pa [6] = '{17, 26, 36, 40, 54, 63};  // byte addresses
      size_t  ps [6] = '{0, 1, 2, 0, 1, 0};
      len_t   pl [6] = '{0, 0, 0, 3, 0, 0};         // 40: four 1 byte transfers
      for (int k = 0; k < 6; k++) issue_write(64'(pa[k]), ps[k], pl[k], rand64());
      for (int k = 0; k < 6; k++) begin
         read_check(64'(pa[k] & ~7), 3'd3, 8'd0);  // neighbours untouched
         read_check(64'(pa[k]), ps[k], pl[k]);     // field in low bytes
      end
      idle();
      end_test("partial writes");
   endtask

   task automatic test_unsigned_atomics();
      atype_t ops [6] = '{atomic_add, atomic_and, atomic_or, atomic_xor, atomic_swap,
                          atype_t'(8'hff)};  // unknown code acts as swap
      logic [63:0] a;
      for (int k = 0; k < 6; k++) begin
         a = 64'(8 * (8 + k) + 4 * (k % 2));
         run_atomic(a, 3'd2, 8'd0, ops[k], rand64());
         read_check(a & ~64'd7, 3'd3, 8'd0);
      end
      idle();
      end_test("unsigned atomics");
   endtask

   task automatic test_compare_atomics();
      atype_t ops [4] = '{atomic_max, atomic_min, atomic_maxu, atomic_minu};
      logic [31:0] neg, pos;
      logic [63:0] a;
      for (int k = 0; k < 8; k++) begin
         neg = $random(seed) | 32'h8000_0000;
         pos = $random(seed) & 32'h7fff_ffff;
         a   = 64'(8 * (16 + k) + 4 * (k % 2));
         // old field and operand swap sign roles in the second half
         issue_write(a, 3'd2, 8'd0, (k < 4) ? 64'(neg) : 64'(pos));
         run_atomic(a, 3'd2, 8'd0, ops[k % 4], (k < 4) ? 64'(pos) : 64'(neg));
         read_check(a & ~64'd7, 3'd3, 8'd0);
      end
      idle();
      end_test("compare atomics");
   endtask

   task automatic test_back_to_back();
      issue_write(64'd160, 3'd3, 8'd0, rand64());
      read_check(64'd160, 3'd3, 8'd0);               // write then read, no gap
      run_atomic(64'd164, 3'd2, 8'd0, atomic_add, rand64());
      read_check(64'd160, 3'd3, 8'd0);               // first cycle with ready back
      idle();
      end_test("back to back");
   endtask

   // ####################
   // main sequence
   // ####################

   initial begin
      nreset = 1'b0;
      atype  = atomic_add;
      set_req(1'b0, 1'b0, 1'b0, '0, '0, '0, '0);
      repeat (4) @(posedge clk);
      #1 nreset = 1'b1;
      tick();
      test_reset();
      test_full_words();
      test_partial();
      test_unsigned_atomics();
      test_compare_atomics();
      test_back_to_back();
      assert_fails = UUT.u_memif.chk.fail_count;
      $display("done: %0d checks, %0d errors, %0d assertion failures",
               checks, errors, assert_fails);
      if ((errors == 0) && (assert_fails == 0)) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* vlog.f */
hw/umi_pkg.sv
hw/mem_pkg.sv
hw/mem_if.sv
hw/umi_atomic_alu.sv
hw/umi_memif.sv
hw/umi_sram.sv
hw/umi_mem_top.sv
sim/umi_mem_checker.sv
sim/tb_umi_mem.sv
